//--- src/mem_stage_settings.svh
`ifndef MEM_STAGE_SETTINGS_SVH
`define MEM_STAGE_SETTINGS_SVH

// register and data width
`define MEM_XLEN 64

// destination register number width
`define MEM_REGNO_W 5

// bytes per memory word
`define MEM_BYTES 8

// 256 words of data memory
`define MEM_DEPTH_LOG2 8

`endif

//--- src/mem_stage_pkg.sv
`include "mem_stage_settings.svh"

package mem_stage_pkg;

  typedef logic [`MEM_XLEN-1:0]       xlen_t;
  typedef logic [`MEM_REGNO_W-1:0]    regno_t;
  typedef logic [`MEM_BYTES-1:0]      byte_en_t;  // one bit per byte lane
  typedef logic [`MEM_DEPTH_LOG2-1:0] word_idx_t;

  // memory opcodes seen by the stage, everything else is op_none
  typedef enum logic [3:0] {
    op_none = 4'd0,
    op_lb   = 4'd1,
    op_lbu  = 4'd2,
    op_lh   = 4'd3,
    op_lhu  = 4'd4,
    op_lw   = 4'd5,
    op_lwu  = 4'd6,
    op_ld   = 4'd7,
    op_sb   = 4'd8,
    op_sh   = 4'd9,
    op_sw   = 4'd10,
    op_sd   = 4'd11
  } mem_op_e;

  typedef enum logic [1:0] {
    sz_byte  = 2'd0,
    sz_half  = 2'd1,
    sz_word  = 2'd2,
    sz_dword = 2'd3
  } mem_size_e;

endpackage

//--- src/mem_request_stage.sv
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module mem_request_stage (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      flush,
  input  logic                      in_valid,
  input  mem_stage_pkg::mem_op_e    in_op,
  input  mem_stage_pkg::xlen_t      in_alu_result,  // address for loads and stores
  input  mem_stage_pkg::xlen_t      in_rs2_value,   // store data
  input  mem_stage_pkg::regno_t     in_rd_regno,
  input  logic                      in_update_rd,
  output logic                      req_valid,
  output mem_stage_pkg::mem_op_e    req_op,
  output logic                      req_is_store,
  output mem_stage_pkg::word_idx_t  req_word_idx,
  output logic [2:0]                req_byte_off,
  output mem_stage_pkg::byte_en_t   req_byte_en,
  output mem_stage_pkg::xlen_t      req_wdata,
  output mem_stage_pkg::xlen_t      req_alu_result,
  output mem_stage_pkg::regno_t     req_rd_regno,
  output logic                      req_update_rd
);
  import mem_stage_pkg::*;

  mem_size_e  size;
  logic       is_store;
  logic [2:0] byte_off;
  byte_en_t   size_mask;
  byte_en_t   byte_en;
  xlen_t      wdata;

  // access width from the opcode
  always_comb begin
    case (in_op)
      op_lb, op_lbu, op_sb: size = sz_byte;
      op_lh, op_lhu, op_sh: size = sz_half;
      op_lw, op_lwu, op_sw: size = sz_word;
      default:              size = sz_dword;  // ld, sd, op_none
    endcase
  end

  assign is_store = (in_op == op_sb) || (in_op == op_sh) ||
                    (in_op == op_sw) || (in_op == op_sd);

  // offset bits below the access size are ignored
  always_comb begin
    case (size)
      sz_byte: begin
        byte_off  = in_alu_result[2:0];
        size_mask = byte_en_t'(8'h01);
      end
      sz_half: begin
        byte_off  = {in_alu_result[2:1], 1'b0};
        size_mask = byte_en_t'(8'h03);
      end
      sz_word: begin
        byte_off  = {in_alu_result[2], 2'b00};
        size_mask = byte_en_t'(8'h0f);
      end
      default: begin
        byte_off  = 3'd0;
        size_mask = '1;
      end
    endcase
  end

  // move the low bytes of rs2 up into the addressed lane
  assign wdata   = in_rs2_value << {byte_off, 3'b000};
  assign byte_en = is_store ? byte_en_t'(size_mask << byte_off) : '0;  // loads write nothing

  always_ff @(posedge clk) begin
    if (reset) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= in_valid & ~flush;  // flush drops the incoming item
    end
  end

  always_ff @(posedge clk) begin
    req_op         <= in_op;
    req_is_store   <= is_store;
    req_word_idx   <= in_alu_result[3 +: `MEM_DEPTH_LOG2];  // address bits above the offset
    req_byte_off   <= byte_off;
    req_byte_en    <= byte_en;
    req_wdata      <= wdata;
    req_alu_result <= in_alu_result;
    req_rd_regno   <= in_rd_regno;
    req_update_rd  <= in_update_rd;
  end

endmodule

//--- src/data_memory.sv
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module data_memory (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      flush,
  input  logic                      req_valid,
  input  mem_stage_pkg::mem_op_e    req_op,
  input  logic                      req_is_store,
  input  mem_stage_pkg::word_idx_t  req_word_idx,
  input  logic [2:0]                req_byte_off,
  input  mem_stage_pkg::byte_en_t   req_byte_en,
  input  mem_stage_pkg::xlen_t      req_wdata,
  input  mem_stage_pkg::xlen_t      req_alu_result,
  input  mem_stage_pkg::regno_t     req_rd_regno,
  input  logic                      req_update_rd,
  output logic                      acc_valid,
  output mem_stage_pkg::mem_op_e    acc_op,
  output logic [2:0]                acc_byte_off,
  output mem_stage_pkg::xlen_t      acc_rdata,
  output mem_stage_pkg::xlen_t      acc_alu_result,
  output mem_stage_pkg::regno_t     acc_rd_regno,
  output logic                      acc_update_rd
);
  import mem_stage_pkg::*;

  localparam int depth = 1 << `MEM_DEPTH_LOG2;

  xlen_t mem [depth];
  logic  wr_en;

  // a store caught by the flush never reaches the array
  assign wr_en = req_valid & req_is_store & ~flush;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < `MEM_BYTES; b++) begin
        if (req_byte_en[b]) begin
          mem[req_word_idx][8*b +: 8] <= req_wdata[8*b +: 8];
        end
      end
    end
    acc_rdata <= mem[req_word_idx];  // read-first, old word on a same-cycle write
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      acc_valid <= 1'b0;
    end else begin
      acc_valid <= req_valid & ~flush;
    end
  end

  // item fields follow the read data
  always_ff @(posedge clk) begin
    acc_op         <= req_op;
    acc_byte_off   <= req_byte_off;
    acc_alu_result <= req_alu_result;
    acc_rd_regno   <= req_rd_regno;
    acc_update_rd  <= req_update_rd;
  end

endmodule

//--- src/load_align_stage.sv
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module load_align_stage (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    flush,
  input  logic                    acc_valid,
  input  mem_stage_pkg::mem_op_e  acc_op,
  input  logic [2:0]              acc_byte_off,
  input  mem_stage_pkg::xlen_t    acc_rdata,
  input  mem_stage_pkg::xlen_t    acc_alu_result,
  input  mem_stage_pkg::regno_t   acc_rd_regno,
  input  logic                    acc_update_rd,
  output logic                    out_valid,
  output mem_stage_pkg::xlen_t    out_mdata,
  output mem_stage_pkg::xlen_t    out_alu_result,
  output mem_stage_pkg::regno_t   out_rd_regno,
  output logic                    out_update_rd
);
  import mem_stage_pkg::*;

  xlen_t lane;
  xlen_t mdata;
  logic  take;

  // addressed lane down to bit 0
  assign lane = acc_rdata >> {acc_byte_off, 3'b000};

  always_comb begin
    case (acc_op)
      op_lb: begin
        mdata = {{(`MEM_XLEN-8){lane[7]}}, lane[7:0]};
      end
      op_lbu: begin
        mdata = {{(`MEM_XLEN-8){1'b0}}, lane[7:0]};
      end
      op_lh: begin
        mdata = {{(`MEM_XLEN-16){lane[15]}}, lane[15:0]};
      end
      op_lhu: begin
        mdata = {{(`MEM_XLEN-16){1'b0}}, lane[15:0]};
      end
      op_lw: begin
        mdata = {{(`MEM_XLEN-32){lane[31]}}, lane[31:0]};
      end
      op_lwu: begin
        mdata = {{(`MEM_XLEN-32){1'b0}}, lane[31:0]};
      end
      op_ld: begin
        mdata = acc_rdata;  // offset is always 0 here
      end
      default: begin
        mdata = '0;  // stores and non-memory ops
      end
    endcase
  end

  assign take = acc_valid & ~flush;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_mdata <= '0;
    end else begin
      out_valid <= take;
      if (take) begin
        out_mdata <= mdata;  // held between items
      end
    end
  end

  always_ff @(posedge clk) begin
    out_alu_result <= acc_alu_result;
    out_rd_regno   <= acc_rd_regno;
    out_update_rd  <= acc_update_rd;
  end

endmodule

//--- src/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    in_flush,  // syscall flush
  input  logic                    in_valid,
  input  mem_stage_pkg::mem_op_e  in_op,
  input  mem_stage_pkg::xlen_t    in_alu_result,
  input  mem_stage_pkg::xlen_t    in_rs2_value,
  input  mem_stage_pkg::regno_t   in_rd_regno,
  input  logic                    in_update_rd,
  output logic                    out_valid,
  output mem_stage_pkg::xlen_t    out_mdata,
  output mem_stage_pkg::xlen_t    out_alu_result,
  output mem_stage_pkg::regno_t   out_rd_regno,
  output logic                    out_update_rd
);
  import mem_stage_pkg::*;

  // stage 1 to stage 2
  logic      req_valid;
  mem_op_e   req_op;
  logic      req_is_store;
  word_idx_t req_word_idx;
  logic [2:0] req_byte_off;
  byte_en_t  req_byte_en;
  xlen_t     req_wdata;
  xlen_t     req_alu_result;
  regno_t    req_rd_regno;
  logic      req_update_rd;

  // stage 2 to stage 3
  logic       acc_valid;
  mem_op_e    acc_op;
  logic [2:0] acc_byte_off;
  xlen_t      acc_rdata;
  xlen_t      acc_alu_result;
  regno_t     acc_rd_regno;
  logic       acc_update_rd;

  mem_request_stage u_request (
    .clk            (clk),
    .reset          (reset),
    .flush          (in_flush),
    .in_valid       (in_valid),
    .in_op          (in_op),
    .in_alu_result  (in_alu_result),
    .in_rs2_value   (in_rs2_value),
    .in_rd_regno    (in_rd_regno),
    .in_update_rd   (in_update_rd),
    .req_valid      (req_valid),
    .req_op         (req_op),
    .req_is_store   (req_is_store),
    .req_word_idx   (req_word_idx),
    .req_byte_off   (req_byte_off),
    .req_byte_en    (req_byte_en),
    .req_wdata      (req_wdata),
    .req_alu_result (req_alu_result),
    .req_rd_regno   (req_rd_regno),
    .req_update_rd  (req_update_rd)
  );

  data_memory u_memory (
    .clk            (clk),
    .reset          (reset),
    .flush          (in_flush),
    .req_valid      (req_valid),
    .req_op         (req_op),
    .req_is_store   (req_is_store),
    .req_word_idx   (req_word_idx),
    .req_byte_off   (req_byte_off),
    .req_byte_en    (req_byte_en),
    .req_wdata      (req_wdata),
    .req_alu_result (req_alu_result),
    .req_rd_regno   (req_rd_regno),
    .req_update_rd  (req_update_rd),
    .acc_valid      (acc_valid),
    .acc_op         (acc_op),
    .acc_byte_off   (acc_byte_off),
    .acc_rdata      (acc_rdata),
    .acc_alu_result (acc_alu_result),
    .acc_rd_regno   (acc_rd_regno),
    .acc_update_rd  (acc_update_rd)
  );

  load_align_stage u_align (
    .clk            (clk),
    .reset          (reset),
    .flush          (in_flush),
    .acc_valid      (acc_valid),
    .acc_op         (acc_op),
    .acc_byte_off   (acc_byte_off),
    .acc_rdata      (acc_rdata),
    .acc_alu_result (acc_alu_result),
    .acc_rd_regno   (acc_rd_regno),
    .acc_update_rd  (acc_update_rd),
    .out_valid      (out_valid),
    .out_mdata      (out_mdata),
    .out_alu_result (out_alu_result),
    .out_rd_regno   (out_rd_regno),
    .out_update_rd  (out_update_rd)
  );

endmodule

//--- dv/mem_ref_model.svh
`ifndef MEM_REF_MODEL_SVH
`define MEM_REF_MODEL_SVH

// shadow copy of the data memory, written in program order
xlen_t shadow_mem [1 << `MEM_DEPTH_LOG2];

// bytes moved by an opcode
function automatic int access_bytes(mem_op_e op);
  case (op)
    op_lb, op_lbu, op_sb: return 1;
    op_lh, op_lhu, op_sh: return 2;
    op_lw, op_lwu, op_sw: return 4;
    default:              return 8;
  endcase
endfunction

function automatic bit is_store_op(mem_op_e op);
  return op inside {op_sb, op_sh, op_sw, op_sd};
endfunction

// low address bits rounded down to the access size
function automatic int lane_offset(mem_op_e op, xlen_t addr);
  int n;
  n = access_bytes(op);
  return (int'(addr[2:0]) / n) * n;
endfunction

function automatic int word_index(xlen_t addr);
  return int'(addr[3 +: `MEM_DEPTH_LOG2]);
endfunction

task automatic store_merge(mem_op_e op, xlen_t addr, xlen_t data);
  int n;
  int off;
  int w;
  n   = access_bytes(op);
  off = lane_offset(op, addr);
  w   = word_index(addr);
  for (int i = 0; i < n; i++) begin
    shadow_mem[w][8*(off+i) +: 8] = data[8*i +: 8];  // byte i of rs2 lands at lane off+i
  end
endtask

function automatic xlen_t load_extract(mem_op_e op, xlen_t addr);
  xlen_t word;
  xlen_t val;
  int    n;
  int    off;
  if (op == op_none || is_store_op(op)) return '0;
  word = shadow_mem[word_index(addr)];
  n    = access_bytes(op);
  off  = lane_offset(op, addr);
  val  = '0;
  for (int i = 0; i < n; i++) begin
    val[8*i +: 8] = word[8*(off+i) +: 8];
  end
  // signed loads fill the upper bytes from the top bit of the lane
  if (op inside {op_lb, op_lh, op_lw} && val[8*n-1]) begin
    for (int i = n; i < 8; i++) begin
      val[8*i +: 8] = 8'hff;
    end
  end
  return val;
endfunction

`endif

//--- dv/mem_stage_tb.sv
`timescale 1ns/1ps
`include "mem_stage_settings.svh"

module mem_stage_tb;
  import mem_stage_pkg::*;

  `include "mem_ref_model.svh"

  localparam int reset_cycles = 8;
  localparam int drain_rows   = 4;  // idle rows that empty the pipe after each test

  typedef struct packed {
    logic [3:0] test;
    logic       valid;
    mem_op_e    op;
    xlen_t      addr;
    xlen_t      rs2;
    regno_t     rd;
    logic       upd;
    logic       flush;
    logic       exp_out;
    xlen_t      exp_mdata;
  } row_t;

  logic    clk;
  logic    reset;
  logic    in_flush;
  logic    in_valid;
  logic    in_update_rd;
  logic    out_valid;
  logic    out_update_rd;
  mem_op_e in_op;
  xlen_t   in_alu_result;
  xlen_t   in_rs2_value;
  xlen_t   out_mdata;
  xlen_t   out_alu_result;
  regno_t  in_rd_regno;
  regno_t  out_rd_regno;

  row_t  tbl[$];
  int    pend[$];  // rows whose output is still due
  int    pass_count = 0;
  int    fail_count = 0;
  int    limit;
  bit    table_ready = 1'b0;
  string test_title [1:5] = '{"sd/ld round trip", "sub-word store merge",
                              "load extension", "random back-to-back", "flush"};

  mem_stage_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic xlen_t rand64();
    return {$urandom, $urandom};
  endfunction

  task automatic compare_value(string name, xlen_t expected, xlen_t actual);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s expected %h got %h", $time, name, expected, actual);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic add_row(int test, logic valid, mem_op_e op, xlen_t addr, xlen_t rs2,
                         logic flush);
    row_t r;
    r       = '0;
    r.test  = test;
    r.valid = valid;
    r.op    = op;
    r.addr  = addr;
    r.rs2   = rs2;
    r.rd    = regno_t'($urandom_range(0, 31));
    r.upd   = $urandom_range(0, 1);
    r.flush = flush;
    tbl.push_back(r);
  endtask

  task automatic add_idle(int test);
    repeat (drain_rows) begin
      add_row(test, 1'b0, op_none, '0, '0, 1'b0);
    end
  endtask

  task automatic build_table();
    mem_op_e op;
    add_row(1, 1, op_sd, 64'h08, rand64(), 0);
    add_row(1, 1, op_ld, 64'h08, '0, 0);  // right behind the store
    add_row(1, 1, op_none, 64'h1234_5678_9abc_def0, rand64(), 0);
    add_row(1, 1, op_ld, 64'h08, '0, 0);
    add_idle(1);
    add_row(2, 1, op_sd, 64'h10, rand64(), 0);
    for (int off = 0; off < 8; off++) begin
      add_row(2, 1, op_sb, 64'h10 + off, rand64(), 0);
      add_row(2, 1, op_ld, 64'h10, '0, 0);  // only the addressed lane may have moved
    end
    for (int off = 0; off < 8; off += 2) begin
      add_row(2, 1, op_sh, 64'h10 + off, rand64(), 0);
      add_row(2, 1, op_ld, 64'h10, '0, 0);
    end
    for (int off = 0; off < 8; off += 4) begin
      add_row(2, 1, op_sw, 64'h10 + off, rand64(), 0);
      add_row(2, 1, op_ld, 64'h10, '0, 0);
    end
    add_idle(2);
    add_row(3, 1, op_sd, 64'h18, 64'hf0e1_d2c3_b4a5_9687, 0);  // every byte negative
    for (int k = 1; k <= 6; k++) begin
      op = mem_op_e'(k);
      for (int off = 0; off < 8; off += access_bytes(op)) begin
        add_row(3, 1, op, 64'h18 + off, '0, 0);
      end
    end
    add_row(3, 1, op_lh, 64'h1b, '0, 0);  // low bit ignored
    add_row(3, 1, op_sb, 64'h48, rand64(), 0);
    add_row(3, 1, op_none, 64'h18, '0, 0);
    add_idle(3);
    for (int w = 4; w < 8; w++) begin
      add_row(4, 1, op_sd, 64'(w * 8), rand64(), 0);
    end
    add_row(4, 1, op_sw, 64'h2c, rand64(), 0);
    add_row(4, 1, op_lwu, 64'h2c, '0, 0);
    repeat (40) begin
      op = mem_op_e'($urandom_range(0, 11));
      add_row(4, 1, op, 64'h20 + $urandom_range(0, 31), rand64(), 0);
    end
    add_idle(4);
    add_row(5, 1, op_sd, 64'h30, rand64(), 0);
    add_row(5, 1, op_ld, 64'h30, '0, 0);  // in stage 2 at the flush
    add_row(5, 1, op_sd, 64'h30, rand64(), 0);  // in stage 1 at the flush
    add_row(5, 1, op_sb, 64'h31, rand64(), 1);
    add_row(5, 1, op_ld, 64'h30, '0, 0);
    add_idle(5);
  endtask

  // row i writes or reads memory unless rows i or i+1 flush, and comes out unless i+2 flushes too
  task automatic predict_outputs();
    row_t r;
    logic f1;
    logic f2;
    for (int i = 0; i < tbl.size(); i++) begin
      r  = tbl[i];
      f1 = (i + 1 < tbl.size()) ? tbl[i+1].flush : 1'b0;
      f2 = (i + 2 < tbl.size()) ? tbl[i+2].flush : 1'b0;
      if (r.valid && !r.flush && !f1) begin
        r.exp_mdata = load_extract(r.op, r.addr);
        if (is_store_op(r.op)) store_merge(r.op, r.addr, r.rs2);
        r.exp_out = !f2;
      end
      tbl[i] = r;
    end
  endtask

  task automatic check_outputs(int t);
    int   idx;
    row_t r;
    if (pend.size() > 0 && pend[0] + 3 == t) begin
      idx = pend.pop_front();
      r   = tbl[idx];
      if (out_valid !== 1'b1) begin
        $display("ERROR at %0t ns: no out_valid for table row %0d", $time, idx);
        fail_count++;
      end else begin
        compare_value("out_mdata", r.exp_mdata, out_mdata);
        compare_value("out_alu_result", r.addr, out_alu_result);
        compare_value("out_rd_regno", r.rd, out_rd_regno);
        compare_value("out_update_rd", r.upd, out_update_rd);
      end
    end else if (out_valid !== 1'b0) begin
      $display("ERROR at %0t ns: out_valid high with no item expected", $time);
      fail_count++;
    end
  endtask

  task automatic drive_row(row_t r);
    in_valid      = r.valid;
    in_op         = r.op;
    in_alu_result = r.addr;
    in_rs2_value  = r.rs2;
    in_rd_regno   = r.rd;
    in_update_rd  = r.upd;
    in_flush      = r.flush;
  endtask

  task automatic print_test(int t, int checks_at, int fails_at);
    $display("test %0d (%s): %0d checks, %0d failed", t, test_title[t],
             pass_count + fail_count - checks_at, fail_count - fails_at);
  endtask

  initial begin
    int cur_test;
    int checks_at;
    int fails_at;
    void'($urandom(79));
    reset         = 1'b1;
    in_flush      = 1'b0;
    in_valid      = 1'b0;
    in_op         = op_none;
    in_alu_result = '0;
    in_rs2_value  = '0;
    in_rd_regno   = '0;
    in_update_rd  = 1'b0;
    build_table();
    predict_outputs();
    limit       = tbl.size() + reset_cycles + 20;
    table_ready = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1 reset = 1'b0;
    compare_value("out_valid", '0, out_valid);
    compare_value("out_mdata", '0, out_mdata);
    cur_test  = tbl[0].test;
    checks_at = pass_count + fail_count;
    fails_at  = fail_count;
    for (int i = 0; i < tbl.size(); i++) begin
      @(posedge clk);
      #1;
      check_outputs(i);
      if (tbl[i].test != cur_test) begin
        print_test(cur_test, checks_at, fails_at);
        cur_test  = tbl[i].test;
        checks_at = pass_count + fail_count;
        fails_at  = fail_count;
      end
      drive_row(tbl[i]);
      if (tbl[i].exp_out) pend.push_back(i);
    end
    if (pend.size() != 0) begin
      $display("ERROR: %0d expected outputs never appeared", pend.size());
      fail_count++;
    end
    print_test(cur_test, checks_at, fails_at);
    $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    int cycles;
    cycles = 0;
    wait (table_ready);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("ERROR: run did not finish within %0d cycles", limit);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- project.f
+incdir+src
+incdir+dv
src/mem_stage_pkg.sv
src/mem_request_stage.sv
src/data_memory.sv
src/load_align_stage.sv
src/mem_stage_top.sv
dv/mem_stage_tb.sv
